/* Bender.yml */
package:
  name: mips_core

sources:
  - rtl/mips_pkg.sv
  - rtl/fetch_stage.sv
  - rtl/reg_file.sv
  - rtl/hazard_unit.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/writeback_stage.sv
  - rtl/mips_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_mips_core.sv

/* flist.f */
+incdir+tb
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/mips_core.sv
tb/tb_mips_core.sv

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 equal,
    input  mips_pkg::word_t      if_instr,
    input  mips_pkg::word_t      if_pc_next,
    input  mips_pkg::word_t      op_a,
    input  mips_pkg::word_t      op_b,
    output mips_pkg::reg_addr_t  rs_addr,
    output mips_pkg::reg_addr_t  rt_addr,
    output mips_pkg::reg_addr_t  ex_rs,
    output mips_pkg::reg_addr_t  ex_rt,
    output mips_pkg::reg_addr_t  ex_dest,
    output logic                 id_branch,
    output logic                 redirect,
    output mips_pkg::word_t      redirect_pc,
    output mips_pkg::word_t      ex_a,
    output mips_pkg::word_t      ex_b,
    output mips_pkg::word_t      ex_imm,
    output mips_pkg::alu_op_e    ex_alu_op,
    output logic                 ex_alu_src,
    output logic                 ex_mem_read,
    output logic                 ex_mem_write,
    output logic                 ex_reg_write,
    output logic                 ex_mem_to_reg
);
    import mips_pkg::*;

    opcode_t   opcode;
    reg_addr_t rd_addr;
    word_t     imm;
    word_t     branch_pc;
    word_t     jump_pc;
    logic      jump;
    logic      reg_dst;     // 1 rd, 0 rt
    logic      alu_src;     // 1 immediate
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      mem_to_reg;
    alu_op_e   alu_op;

    assign opcode  = if_instr[31:26];
    assign rs_addr = if_instr[25:21];
    assign rt_addr = if_instr[20:16];
    assign rd_addr = if_instr[15:11];
    assign imm     = {{16{if_instr[15]}}, if_instr[15:0]};  // sign extend

    // --------------------------------------------------------------------------
    // control decode
    // --------------------------------------------------------------------------
    always_comb begin
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        id_branch  = 1'b0;
        jump       = 1'b0;
        alu_op     = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                alu_op    = ALU_FUNCT;
            end
            OP_ADDI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ:  id_branch = 1'b1;   // resolved here and not in ex
            OP_J:    jump = 1'b1;
            default: alu_op = ALU_ADD;   // anything else runs as a nop
        endcase
    end

    // targets relative to pc+4
    assign branch_pc   = if_pc_next + {imm[29:0], 2'b00};
    assign jump_pc     = {if_pc_next[31:28], if_instr[25:0], 2'b00};
    assign redirect_pc = jump ? jump_pc : branch_pc;
    assign redirect    = !stall && (jump || (id_branch && equal));

    // --------------------------------------------------------------------------
    // ID/EX register
    // --------------------------------------------------------------------------
    // a stall turns the control part into a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_alu_op     <= ALU_ADD;
            ex_alu_src    <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
        end else begin
            ex_alu_op     <= stall ? ALU_ADD : alu_op;
            ex_alu_src    <= alu_src && !stall;
            ex_mem_read   <= mem_read && !stall;
            ex_mem_write  <= mem_write && !stall;
            ex_reg_write  <= reg_write && !stall;
            ex_mem_to_reg <= mem_to_reg && !stall;
        end
    end

    // operands and indices
    always_ff @(posedge clk) begin
        ex_a    <= op_a;     // already bypassed in reg_file
        ex_b    <= op_b;
        ex_imm  <= imm;      // low 6 bits double as funct
        ex_rs   <= rs_addr;
        ex_rt   <= rt_addr;
        ex_dest <= reg_dst ? rd_addr : rt_addr;
    end

    // the instruction held back by a bubble must come round again
    a_stall_holds_if_id: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(if_instr) && $stable(if_pc_next))
        else $error("IF/ID moved while a bubble went into ID/EX");

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::word_t     ex_a,
    input  mips_pkg::word_t     ex_b,
    input  mips_pkg::word_t     ex_imm,
    input  mips_pkg::alu_op_e   ex_alu_op,
    input  mips_pkg::reg_addr_t ex_dest,
    input  logic                ex_alu_src,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  logic                ex_reg_write,
    input  logic                ex_mem_to_reg,
    input  mips_pkg::fwd_sel_t  fwd_a,
    input  mips_pkg::fwd_sel_t  fwd_b,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::word_t     mem_alu,
    output mips_pkg::word_t     mem_wdata,
    output mips_pkg::reg_addr_t mem_dest,
    output logic                mem_mem_read,
    output logic                mem_mem_write,
    output logic                mem_reg_write,
    output logic                mem_mem_to_reg
);
    import mips_pkg::*;

    word_t   src_a;
    word_t   src_b;      // also the store data
    word_t   alu_b;
    word_t   alu_y;
    alu_op_e op;

    // operand bypass
    assign src_a = (fwd_a == 2'd1) ? mem_alu : (fwd_a == 2'd2) ? wb_data : ex_a;
    assign src_b = (fwd_b == 2'd1) ? mem_alu : (fwd_b == 2'd2) ? wb_data : ex_b;
    assign alu_b = ex_alu_src ? ex_imm : src_b;

    // r-type: pick op from funct
    always_comb begin
        op = ex_alu_op;
        if (ex_alu_op == ALU_FUNCT) begin
            case (ex_imm[5:0])
                FN_ADD:  op = ALU_ADD;
                FN_SUB:  op = ALU_SUB;
                FN_AND:  op = ALU_AND;
                FN_OR:   op = ALU_OR;
                FN_SLT:  op = ALU_SLT;
                default: op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (op)
            ALU_SUB: alu_y = src_a - alu_b;
            ALU_AND: alu_y = src_a & alu_b;
            ALU_OR:  alu_y = src_a | alu_b;
            ALU_SLT: alu_y = {31'b0, $signed(src_a) < $signed(alu_b)};
            default: alu_y = src_a + alu_b;   // add, addi, lw/sw address
        endcase
    end

    // EX/MEM register, control part
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_mem_read   <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_reg_write  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
        end else begin
            mem_mem_read   <= ex_mem_read;
            mem_mem_write  <= ex_mem_write;
            mem_reg_write  <= ex_reg_write;
            mem_mem_to_reg <= ex_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu   <= alu_y;
        mem_wdata <= src_b;
        mem_dest  <= ex_dest;
    end

    a_fwd_sel_legal: assert property (@(posedge clk) disable iff (!rst_n)
        fwd_a != 2'd3 && fwd_b != 2'd3)
        else $error("illegal forward select");

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            redirect,
    input  mips_pkg::word_t redirect_pc,
    input  mips_pkg::word_t imem_data,
    output mips_pkg::word_t imem_addr,
    output mips_pkg::word_t if_instr,
    output mips_pkg::word_t if_pc_next
);
    import mips_pkg::*;

    word_t pc;
    word_t pc_plus4;
    word_t pc_in;

    assign pc_plus4  = pc + 32'd4;
    assign pc_in     = redirect ? redirect_pc : pc_plus4;  // taken beq / j from decode
    assign imem_addr = pc;                                  // memory answers same cycle

    // program counter, frozen on stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc_in;
        end
    end

    // IF/ID register
    // on redirect the word fetched this cycle is dropped, all-zero decodes as nop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_instr   <= '0;
            if_pc_next <= RESET_PC;
        end else if (!stall) begin
            if_instr   <= redirect ? '0 : imem_data;
            if_pc_next <= pc_plus4;
        end
    end

    // decode holds its redirect back while the hazard unit stalls
    a_no_stall_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        !(stall && redirect))
        else $error("stall and redirect high together");

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  mips_pkg::reg_addr_t id_rs,
    input  mips_pkg::reg_addr_t id_rt,
    input  mips_pkg::reg_addr_t ex_rs,
    input  mips_pkg::reg_addr_t ex_rt,
    input  mips_pkg::reg_addr_t ex_dest,
    input  mips_pkg::reg_addr_t mem_dest,
    input  mips_pkg::reg_addr_t wb_reg,
    input  logic                id_branch,
    input  logic                ex_mem_read,
    input  logic                ex_reg_write,
    input  logic                mem_mem_read,
    input  logic                mem_reg_write,
    input  logic                wb_we,
    output logic                stall,
    output mips_pkg::fwd_sel_t  fwd_a,
    output mips_pkg::fwd_sel_t  fwd_b,
    output mips_pkg::fwd_sel_t  fwd_c,
    output mips_pkg::fwd_sel_t  fwd_d
);
    import mips_pkg::*;

    logic load_use;
    logic branch_dep;
    logic mem_ok;      // ex/mem holds a finished alu result
    logic wb_ok;

    // --------------------------------------------------------------------------
    // stalls
    // --------------------------------------------------------------------------
    // load in ex, consumer in id
    assign load_use = ex_mem_read && ex_rt != '0 && (ex_rt == id_rs || ex_rt == id_rt);

    // beq compares in id, so producers still in ex, or a load in mem, hold it
    assign branch_dep = id_branch && (
        (ex_reg_write && ex_dest != '0 && (ex_dest == id_rs || ex_dest == id_rt)) ||
        (mem_mem_read && mem_dest != '0 && (mem_dest == id_rs || mem_dest == id_rt)));

    assign stall = load_use || branch_dep;

    // --------------------------------------------------------------------------
    // forwarding selects, ex/mem first, then write-back
    // --------------------------------------------------------------------------
    assign mem_ok = mem_reg_write && !mem_mem_read && mem_dest != '0;  // load data not ready
    assign wb_ok  = wb_we && wb_reg != '0;

    function automatic fwd_sel_t fwd_pick(input reg_addr_t src);
        if (mem_ok && mem_dest == src) begin
            return 2'd1;
        end else if (wb_ok && wb_reg == src) begin
            return 2'd2;
        end
        return 2'd0;
    endfunction

    always_comb begin
        fwd_a = fwd_pick(ex_rs);  // alu in
        fwd_b = fwd_pick(ex_rt);
        fwd_c = fwd_pick(id_rs);  // decode operands
        fwd_d = fwd_pick(id_rt);
    end

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic            clk,
    input  logic            rst_n,
    output mips_pkg::word_t imem_addr,
    input  mips_pkg::word_t imem_data,
    output mips_pkg::word_t dmem_addr,
    output mips_pkg::word_t dmem_wdata,
    output logic            dmem_we,
    output logic            dmem_re,
    input  mips_pkg::word_t dmem_rdata
);
    import mips_pkg::*;

    // --------------------------------------------------------------------------
    // stage-to-stage nets, named as the ports they join
    // --------------------------------------------------------------------------
    word_t     if_instr;
    word_t     if_pc_next;
    word_t     redirect_pc;
    word_t     op_a;
    word_t     op_b;
    word_t     ex_a;
    word_t     ex_b;
    word_t     ex_imm;
    word_t     mem_alu;
    word_t     mem_wdata;
    word_t     wb_data;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t ex_rs;
    reg_addr_t ex_rt;
    reg_addr_t ex_dest;
    reg_addr_t mem_dest;
    reg_addr_t wb_reg;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    fwd_sel_t  fwd_c;
    fwd_sel_t  fwd_d;
    alu_op_e   ex_alu_op;
    logic      stall;
    logic      redirect;
    logic      equal;
    logic      id_branch;
    logic      ex_alu_src;
    logic      ex_mem_read;
    logic      ex_mem_write;
    logic      ex_reg_write;
    logic      ex_mem_to_reg;
    logic      mem_mem_read;
    logic      mem_mem_write;
    logic      mem_reg_write;
    logic      mem_mem_to_reg;
    logic      wb_we;

    fetch_stage u_fetch (.*);    // pc, if/id

    reg_file u_reg_file (
        .ex_mem_value (mem_alu),  // decode bypass from ex/mem
        .*
    );

    hazard_unit u_hazard (
        .id_rs (rs_addr),
        .id_rt (rt_addr),
        .*
    );

    decode_stage    u_decode  (.*);  // control, targets, id/ex
    execute_stage   u_execute (.*);  // alu, ex/mem
    writeback_stage u_wb      (.*);  // mem/wb

    // data port straight off ex/mem
    assign dmem_addr  = mem_alu;
    assign dmem_wdata = mem_wdata;
    assign dmem_we    = mem_mem_write;
    assign dmem_re    = mem_mem_read;

endmodule

`default_nettype wire

/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // --------------------------------------------------------------------------
    // widths with a meaning
    // --------------------------------------------------------------------------
    typedef logic [31:0] word_t;      // data, address, instruction
    typedef logic [4:0]  reg_addr_t;  // r0..r31
    typedef logic [5:0]  opcode_t;    // instr[31:26]
    typedef logic [1:0]  fwd_sel_t;   // 0 reg, 1 ex/mem, 2 write-back

    // alu op as carried down the pipe
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_FUNCT   // r-type, real op sits in funct
    } alu_op_e;

    // --------------------------------------------------------------------------
    // opcodes
    // --------------------------------------------------------------------------
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // funct field, r-type only
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam word_t RESET_PC = 32'h0000_0000;  // first fetch

endpackage

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  mips_pkg::reg_addr_t wb_reg,
    input  logic                wb_we,
    input  mips_pkg::word_t     wb_data,
    input  mips_pkg::word_t     ex_mem_value,
    input  mips_pkg::fwd_sel_t  fwd_c,
    input  mips_pkg::fwd_sel_t  fwd_d,
    output mips_pkg::word_t     op_a,
    output mips_pkg::word_t     op_b,
    output logic                equal
);
    import mips_pkg::*;

    word_t regs [1:31];  // r0 has no storage
    word_t rd_a;
    word_t rd_b;

    // write port, driven by write-back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_reg != '0) begin
            regs[wb_reg] <= wb_data;
        end
    end

    assign rd_a = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rd_b = (rt_addr == '0) ? '0 : regs[rt_addr];

    // decode-stage bypass, the written value is not yet visible here
    assign op_a = (fwd_c == 2'd1) ? ex_mem_value : (fwd_c == 2'd2) ? wb_data : rd_a;
    assign op_b = (fwd_d == 2'd1) ? ex_mem_value : (fwd_d == 2'd2) ? wb_data : rd_b;

    assign equal = (op_a == op_b);  // beq compare

endmodule

`default_nettype wire

/* rtl/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::word_t     mem_alu,
    input  mips_pkg::word_t     dmem_rdata,
    input  mips_pkg::reg_addr_t mem_dest,
    input  logic                mem_reg_write,
    input  logic                mem_mem_to_reg,
    output logic                wb_we,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data
);
    import mips_pkg::*;

    logic  wb_mem_to_reg;
    word_t wb_alu;
    word_t wb_load;

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we         <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end else begin
            wb_we         <= mem_reg_write;
            wb_mem_to_reg <= mem_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= mem_dest;
        wb_alu  <= mem_alu;
        wb_load <= dmem_rdata;   // memory answered in the mem cycle
    end

    assign wb_data = wb_mem_to_reg ? wb_load : wb_alu;  // also an ex bypass source

endmodule

`default_nettype wire

/* tb/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// --------------------------------------------------------------------------
// random source, galois lfsr, one step per bit
// --------------------------------------------------------------------------
logic [31:0] lfsr_state;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // taps 32,30,26,25
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// --------------------------------------------------------------------------
// instruction-level model, one instruction per step
// --------------------------------------------------------------------------
word_t m_regs [0:31];
word_t m_mem  [0:DMEM_WORDS-1];
word_t exp_addr [$];     // stores in program order
word_t exp_data [$];
logic  model_done;

task automatic run_model();
    word_t pc;
    word_t pc4;
    word_t ins;
    word_t a;
    word_t b;
    word_t imm;
    word_t res;
    int    steps;
    int    i;
    pc = RESET_PC;
    steps = 0;
    model_done = 1'b0;
    for (i = 0; i < 32; i++) begin
        m_regs[i] = '0;
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
        m_mem[i] = fill_word(i);  // same start image as the bus memory
    end
    while (!model_done && steps < 4 * PROG_LEN) begin
        ins = prog[pc[IMEM_AW+1:2]];
        a   = m_regs[ins[25:21]];
        b   = m_regs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        pc4 = pc + 32'd4;
        res = '0;
        case (ins[31:26])
            OP_RTYPE: begin
                case (ins[5:0])
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: res = a + b;
                endcase
                m_regs[ins[15:11]] = res;
            end
            OP_ADDI: m_regs[ins[20:16]] = a + imm;
            OP_LW:   m_regs[ins[20:16]] = m_mem[(a + imm) >> 2];
            OP_SW: begin
                m_mem[(a + imm) >> 2] = b;
                exp_addr.push_back(a + imm);
                exp_data.push_back(b);
            end
            OP_BEQ: begin
                if (a == b) begin
                    pc4 = pc4 + {imm[29:0], 2'b00};  // relative to pc+4
                end
            end
            OP_J: begin
                res = {pc4[31:28], ins[25:0], 2'b00};
                model_done = (res == pc);  // jump to itself ends the program
                pc4 = res;
            end
            default: res = '0;  // anything else is a nop
        endcase
        m_regs[0] = '0;
        pc = pc4;
        steps++;
    end
endtask

`endif

/* tb/tb_mips_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
    import mips_pkg::*;

    localparam int RAND_LEN       = 60;            // random body
    localparam int PROG_LEN       = RAND_LEN + 8;  // + 7 dump stores + final jump
    localparam int IMEM_AW        = 7;
    localparam int IMEM_WORDS     = 1 << IMEM_AW;
    localparam int DMEM_AW        = 6;
    localparam int DMEM_WORDS     = 1 << DMEM_AW;
    localparam int DUMP_BASE      = 128;           // byte address above the random stores
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = 3 * PROG_LEN + 40;
    localparam logic [31:0] LFSR_SEED = 32'd3476;

    logic  clk;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  dmem_we;
    logic  dmem_re;

    word_t prog [0:IMEM_WORDS-1];
    word_t dmem [0:DMEM_WORDS-1];
    int    store_idx;
    int    cycle_count;
    int    check_count;
    int    mismatch_count;
    int    fail_count;
    int    i;

    `include "isa_model.svh"

    mips_core DUT (.*);

    // both memories answer in the same cycle
    assign imem_data  = prog[imem_addr[IMEM_AW+1:2]];
    assign dmem_rdata = dmem[dmem_addr[DMEM_AW+1:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t fill_word(input int idx);
        return 32'h5A00_0000 ^ (32'(idx) * 32'h0001_0203);  // distinct per word
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_reset_outputs();
        check_value(imem_addr, RESET_PC, "fetch address in reset");
        check_value({31'b0, dmem_we}, 32'd0, "dmem_we in reset");
        check_value({31'b0, dmem_re}, 32'd0, "dmem_re in reset");
    endtask

    // --------------------------------------------------------------------------
    // random program with forward branches only and a register dump at the end
    // --------------------------------------------------------------------------
    task automatic build_program();
        int        n;
        int        skip;
        int        kind;
        int        fn_sel;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [3:0] off;
        logic [7:0] imm8;
        logic [5:0] fn;
        for (n = 0; n < IMEM_WORDS; n++) begin
            prog[n] = '0;
        end
        for (n = 0; n < RAND_LEN; n++) begin
            kind   = rand_bits(3);
            rs     = 5'(rand_bits(3));  // r0..r7 only
            rt     = 5'(rand_bits(3));
            rd     = 5'(rand_bits(3));
            off    = 4'(rand_bits(4));
            imm8   = 8'(rand_bits(8));
            skip   = rand_bits(2);
            fn_sel = rand_bits(3) % 5;
            if (n + 1 + skip > RAND_LEN) begin
                skip = RAND_LEN - 1 - n;  // never past the dump
            end
            case (fn_sel)
                0:       fn = FN_ADD;
                1:       fn = FN_SUB;
                2:       fn = FN_AND;
                3:       fn = FN_OR;
                default: fn = FN_SLT;
            endcase
            case (kind)
                0, 1:    prog[n] = {OP_RTYPE, rs, rt, rd, 5'd0, fn};
                2, 6:    prog[n] = {OP_ADDI, rs, rt, {8{imm8[7]}}, imm8};
                3:       prog[n] = {OP_LW, 5'd0, rt, 10'd0, off, 2'b00};
                4:       prog[n] = {OP_SW, 5'd0, rt, 10'd0, off, 2'b00};
                5:       prog[n] = {OP_BEQ, rs, rt, 16'(skip)};
                default: prog[n] = {OP_J, 26'(n + 1 + skip)};
            endcase
        end
        for (n = 1; n < 8; n++) begin
            prog[RAND_LEN+n-1] = {OP_SW, 5'd0, 5'(n), 16'(DUMP_BASE + 4 * n)};
        end
        prog[RAND_LEN+7] = {OP_J, 26'(RAND_LEN + 7)};  // park here
    endtask

    // --------------------------------------------------------------------------
    // store monitor with the data memory write port and the cycle counter
    // --------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (dmem_we) begin
                if (store_idx < exp_addr.size()) begin
                    check_value(dmem_addr, exp_addr[store_idx], "store address");
                    check_value(dmem_wdata, exp_data[store_idx], "store data");
                end else begin
                    fail_count++;
                    $display("extra store of %h to %h at %0t, past the end of the program",
                             dmem_wdata, dmem_addr, $time);
                end
                store_idx++;
                dmem[dmem_addr[DMEM_AW+1:2]] <= dmem_wdata;
            end
        end
    end

    initial begin
        rst_n          = 1'b0;
        store_idx      = 0;
        cycle_count    = 0;
        check_count    = 0;
        mismatch_count = 0;
        fail_count     = 0;
        lfsr_state     = LFSR_SEED;
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(i);
        end
        build_program();
        run_model();
        if (!model_done) begin
            fail_count++;
            $display("reference model never reached the final jump");
        end

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            check_reset_outputs();
        end
        rst_n <= 1'b1;
        @(posedge clk);
        check_reset_outputs();  // first cycle out of reset

        // the run always lasts to the cycle limit so later stores are extra
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        @(negedge clk);

        if (store_idx < exp_addr.size()) begin
            fail_count++;
            $display("cycle limit reached with %0d of %0d stores committed",
                     store_idx, exp_addr.size());
        end
        check_value(32'(store_idx), 32'(exp_addr.size()), "store count");
        for (i = 1; i < 8; i++) begin
            check_value(dmem[(DUMP_BASE >> 2) + i], m_regs[i], $sformatf("dump of r%0d", i));
        end

        $display("checks %0d, mismatches %0d, other failures %0d",
                 check_count, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
